/* flist.f */
rtl/eng_bus_pkg.sv
rtl/eng_cfg_pkg.sv
rtl/engine_ctrl.sv
rtl/rd_addr_gen.sv
rtl/atom_deser.sv
rtl/pool_lanes.sv
rtl/result_ser.sv
rtl/pool_engine.sv
tests/tb_dma_mem.sv
tests/tb_pool_engine.sv

/* rtl/atom_deser.sv */
`timescale 1ns/1ps

module atom_deser import eng_bus_pkg::*; #(
	parameter int LANES = DEF_LANES
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_rd_we,
	input  logic [DATA_W-1:0] i_rd_data,
	output atom_t             o_atom,
	output logic              o_atom_stb
);

	localparam int CW = (LANES > 1) ? $clog2(LANES) : 1;

	logic [CW-1:0] cnt; // Words of the current atom so far

	// New word enters at the top, lane 0 ends up lowest
	always_ff @(posedge clk) begin
		if (i_rd_we) begin
			for (int l = 0; l < LANES - 1; l++) o_atom[l] <= o_atom[l + 1];
			o_atom[LANES-1] <= i_rd_data;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt        <= '0;
			o_atom_stb <= 1'b0;
		end else begin
			o_atom_stb <= i_rd_we && (cnt == CW'(LANES - 1)); // Full atom next cycle
			if (i_rd_we) cnt <= (cnt == CW'(LANES - 1)) ? '0 : cnt + 1'b1;
		end
	end

endmodule

/* rtl/eng_bus_pkg.sv */
package eng_bus_pkg;

	localparam int DEF_LANES = 16; // Channels per atom unless the top overrides
	localparam int DATA_W    = 16; // One channel value, also the DMA word
	localparam int ADDR_W    = 30; // DMA word address

	// One atom, lane 0 sits in the low word
	typedef logic [DEF_LANES-1:0][DATA_W-1:0] atom_t;

	// p2 read side
	typedef struct packed {
		logic              en;   // Level, engine wants words
		logic [ADDR_W-1:0] addr; // Address of the next expected word
	} rd_cmd_t;

	// p0 write side
	typedef struct packed {
		logic              writes_en; // Level, a pooled atom is waiting
		logic [ADDR_W-1:0] addr;      // First word of the atom
		logic [DATA_W-1:0] data;      // Lane word
		logic              valid;     // data holds a lane this cycle
	} wr_cmd_t;

endpackage

/* rtl/eng_cfg_pkg.sv */
package eng_cfg_pkg;
	import eng_bus_pkg::*;

	// Pooling opcodes as carried in the layer command
	typedef enum logic [2:0] {
		OP_MAXPOOL = 3'd4, // Unsigned max over the window
		OP_AVEPOOL = 3'd5  // Window sum then shift
	} op_e;

	// Latched layer command
	typedef struct packed {
		op_e               op;
		logic [3:0]        stride;       // Atoms between window starts
		logic [7:0]        kernel;       // Window side in atoms
		logic [7:0]        i_side;       // Input row length in atoms
		logic [7:0]        o_side;       // Pooled atoms per command
		logic [ADDR_W-1:0] data_start;   // Word address of first input atom
		logic [ADDR_W-1:0] result_start; // Word address of first result atom
	} layer_cfg_t;

	// Only the two pooling ops start the engine
	function automatic logic is_pool_op(input op_e op);
		logic hit;
		hit = (op == OP_MAXPOOL) || (op == OP_AVEPOOL);
		return hit;
	endfunction

endpackage

/* rtl/engine_ctrl.sv */
`timescale 1ns/1ps

module engine_ctrl import eng_cfg_pkg::*, eng_bus_pkg::*; #(
	parameter int LANES = DEF_LANES
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       i_engine_valid,
	input  layer_cfg_t i_cfg,
	input  logic       i_rd_we,
	input  logic       i_atom_stb,
	input  logic       i_full,
	input  logic       i_wr_done,
	output layer_cfg_t o_cfg,
	output logic       o_rd_en,
	output logic       o_first,
	output logic       o_last,
	output logic       o_start,
	output logic       o_engine_ready
);

	localparam int CW = (LANES > 1) ? $clog2(LANES) : 1;

	typedef enum logic [1:0] {
		ST_IDLE,   // After reset, waiting for a command
		ST_BUSY,   // Reading, pooling and writing one row
		ST_FINISH  // Row done, ready stays high
	} state_e;

	state_e        state;
	logic [CW-1:0] wcnt;      // Word inside the atom being read
	logic [15:0]   rd_acnt;   // Atom being read inside the window
	logic [15:0]   pl_acnt;   // Atom being pooled inside the window
	logic [15:0]   ksq;       // Atoms per window
	logic [7:0]    win_rd;    // Windows fully read
	logic [7:0]    out_cnt;   // Atoms written back
	logic          accept;
	logic          word_end;
	logic          rd_last_atom;

	assign ksq          = {8'd0, o_cfg.kernel} * {8'd0, o_cfg.kernel};
	assign accept       = i_engine_valid && (state != ST_BUSY) && is_pool_op(i_cfg.op);
	assign word_end     = i_rd_we && (wcnt == CW'(LANES - 1)); // Atom completes on this word
	assign rd_last_atom = (rd_acnt == ksq - 16'd1);

	// Hold off the last atom of a window while the holding register is taken,
	// so at most one window is in read and one in write-back
	assign o_rd_en = (state == ST_BUSY) && !o_start && (win_rd != o_cfg.o_side) &&
		!(i_full && rd_last_atom);

	assign o_first = (pl_acnt == 16'd0);       // Pool loads instead of combining
	assign o_last  = (pl_acnt == ksq - 16'd1); // Pool emits after this atom

	always_ff @(posedge clk) begin
		if (accept) o_cfg <= i_cfg; // Command held for the whole row
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state          <= ST_IDLE;
			o_start        <= 1'b0;
			o_engine_ready <= 1'b0;
			wcnt           <= '0;
			rd_acnt        <= '0;
			pl_acnt        <= '0;
			win_rd         <= '0;
			out_cnt        <= '0;
		end else begin
			o_start <= accept; // Datapath reloads its bases next cycle
			if (accept) begin
				state          <= ST_BUSY;
				o_engine_ready <= 1'b0;
				wcnt           <= '0;
				rd_acnt        <= '0;
				pl_acnt        <= '0;
				win_rd         <= '0;
				out_cnt        <= '0;
			end else if (state == ST_BUSY) begin
				if (i_rd_we) begin
					wcnt <= word_end ? '0 : wcnt + 1'b1;
					if (word_end) begin
						if (rd_last_atom) begin // Window fully read
							rd_acnt <= '0;
							win_rd  <= win_rd + 8'd1;
						end else begin
							rd_acnt <= rd_acnt + 16'd1;
						end
					end
				end
				if (i_atom_stb) pl_acnt <= o_last ? '0 : pl_acnt + 16'd1;
				if (i_wr_done) begin
					out_cnt <= out_cnt + 8'd1;
					if (out_cnt == o_cfg.o_side - 8'd1) begin // Last atom of the row is out
						state          <= ST_FINISH;
						o_engine_ready <= 1'b1;
					end
				end
			end
		end
	end

endmodule

/* rtl/pool_engine.sv */
`timescale 1ns/1ps

module pool_engine import eng_cfg_pkg::*, eng_bus_pkg::*; #(
	parameter int LANES = DEF_LANES
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_engine_valid,
	input  layer_cfg_t        i_cfg,
	output logic              o_engine_ready,
	output rd_cmd_t           o_rd,
	input  logic              i_rd_we,
	input  logic [DATA_W-1:0] i_rd_data,
	output wr_cmd_t           o_wr,
	input  logic              i_wr_re
);

	layer_cfg_t cfg;        // Latched command
	logic       rd_en;
	logic       start;      // Bases reload
	logic       first;
	logic       last;
	atom_t      atom;
	logic       atom_stb;
	atom_t      result;
	logic       result_stb;
	logic       full;       // Holding register taken
	logic       wr_done;

	engine_ctrl #(.LANES(LANES)) engine_ctrl_inst (
		.clk, .rst, .i_engine_valid, .i_cfg, .i_rd_we,
		.i_atom_stb(atom_stb), .i_full(full), .i_wr_done(wr_done),
		.o_cfg(cfg), .o_rd_en(rd_en), .o_first(first), .o_last(last),
		.o_start(start), .o_engine_ready
	);

	rd_addr_gen #(.LANES(LANES)) rd_addr_gen_inst (
		.clk, .rst, .i_start(start), .i_cfg(cfg), .i_en(rd_en), .i_rd_we, .o_rd
	);

	atom_deser #(.LANES(LANES)) atom_deser_inst (
		.clk, .rst, .i_rd_we, .i_rd_data, .o_atom(atom), .o_atom_stb(atom_stb)
	);

	pool_lanes #(.LANES(LANES)) pool_lanes_inst (
		.clk, .rst, .i_cfg(cfg), .i_atom(atom), .i_atom_stb(atom_stb),
		.i_first(first), .i_last(last), .o_result(result), .o_result_stb(result_stb)
	);

	result_ser #(.LANES(LANES)) result_ser_inst (
		.clk, .rst, .i_start(start), .i_cfg(cfg), .i_result(result),
		.i_result_stb(result_stb), .i_wr_re, .o_wr, .o_full(full), .o_wr_done(wr_done)
	);

endmodule

/* rtl/pool_lanes.sv */
`timescale 1ns/1ps

module pool_lanes import eng_cfg_pkg::*, eng_bus_pkg::*; #(
	parameter int LANES = DEF_LANES
) (
	input  logic       clk,
	input  logic       rst,
	input  layer_cfg_t i_cfg,
	input  atom_t      i_atom,
	input  logic       i_atom_stb,
	input  logic       i_first,
	input  logic       i_last,
	output atom_t      o_result,
	output logic       o_result_stb
);

	localparam int ACC_W = DATA_W + 4; // Room for a 4x4 window sum

	logic [LANES-1:0][ACC_W-1:0] acc; // Running value per lane
	logic [LANES-1:0][ACC_W-1:0] nxt;
	logic [2:0]                  shift; // 2*log2(kernel)
	logic                        is_ave;

	assign is_ave = (i_cfg.op == OP_AVEPOOL);

	always_comb begin
		case (i_cfg.kernel)
			8'd2:    shift = 3'd2;
			8'd4:    shift = 3'd4;
			default: shift = 3'd0; // Kernel 1
		endcase
	end

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			if (i_first) nxt[l] = ACC_W'(i_atom[l]);            // Window opens
			else if (is_ave) nxt[l] = acc[l] + ACC_W'(i_atom[l]);
			else nxt[l] = (ACC_W'(i_atom[l]) > acc[l]) ? ACC_W'(i_atom[l]) : acc[l];
		end
	end

	always_ff @(posedge clk) begin
		if (i_atom_stb) acc <= nxt;
		if (i_atom_stb && i_last) begin
			for (int l = 0; l < LANES; l++) begin
				if (is_ave) o_result[l] <= DATA_W'(nxt[l] >> shift);
				else o_result[l] <= nxt[l][DATA_W-1:0]; // Max stays within 16 bits
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) o_result_stb <= 1'b0;
		else o_result_stb <= i_atom_stb && i_last;
	end

endmodule

/* rtl/rd_addr_gen.sv */
`timescale 1ns/1ps

module rd_addr_gen import eng_cfg_pkg::*, eng_bus_pkg::*; #(
	parameter int LANES = DEF_LANES
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       i_start,
	input  layer_cfg_t i_cfg,
	input  logic       i_en,
	input  logic       i_rd_we,
	output rd_cmd_t    o_rd
);

	localparam logic [ADDR_W-1:0] LANES_A = ADDR_W'(LANES);

	logic [ADDR_W-1:0] win_base; // First word of the current window
	logic [ADDR_W-1:0] block;    // First word of the current atom
	logic [ADDR_W-1:0] offset;   // Word inside the atom
	logic [ADDR_W-1:0] row_jump; // Last atom of a row to first atom of the next
	logic [ADDR_W-1:0] win_step;
	logic [7:0]        col;      // Atom column inside the window
	logic [7:0]        row;      // Atom row inside the window
	logic              atom_end;
	logic              row_end;

	// Back over kernel-1 atoms, then down one input row
	assign row_jump = (ADDR_W'(i_cfg.i_side) - ADDR_W'(i_cfg.kernel) + 1'b1) * LANES_A;
	assign win_step = ADDR_W'(i_cfg.stride) * LANES_A;
	assign atom_end = (offset == LANES_A - 1'b1);
	assign row_end  = (col == i_cfg.kernel - 8'd1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			win_base <= '0;
			block    <= '0;
			offset   <= '0;
			col      <= '0;
			row      <= '0;
		end else if (i_start) begin
			win_base <= i_cfg.data_start;
			block    <= i_cfg.data_start;
			offset   <= '0;
			col      <= '0;
			row      <= '0;
		end else if (i_rd_we) begin
			offset <= atom_end ? '0 : offset + 1'b1;
			if (atom_end) begin
				if (!row_end) begin
					col   <= col + 8'd1;
					block <= block + LANES_A; // Next atom in the row
				end else if (row != i_cfg.kernel - 8'd1) begin
					col   <= '0;
					row   <= row + 8'd1;
					block <= block + row_jump;
				end else begin // Window done, slide by stride atoms
					col      <= '0;
					row      <= '0;
					win_base <= win_base + win_step;
					block    <= win_base + win_step;
				end
			end
		end
	end

	assign o_rd = '{en: i_en, addr: block + offset};

endmodule

/* rtl/result_ser.sv */
`timescale 1ns/1ps

module result_ser import eng_cfg_pkg::*, eng_bus_pkg::*; #(
	parameter int LANES = DEF_LANES
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       i_start,
	input  layer_cfg_t i_cfg,
	input  atom_t      i_result,
	input  logic       i_result_stb,
	input  logic       i_wr_re,
	output wr_cmd_t    o_wr,
	output logic       o_full,
	output logic       o_wr_done
);

	localparam int                CW      = (LANES > 1) ? $clog2(LANES) : 1;
	localparam logic [ADDR_W-1:0] LANES_A = ADDR_W'(LANES);

	atom_t             hold;      // Pooled atom, shifts down one lane per word
	logic [CW-1:0]     wcnt;      // Lanes already requested
	logic              writes_en;
	logic              valid;
	logic [DATA_W-1:0] data;
	logic [ADDR_W-1:0] addr;
	logic              re_ok;
	logic              last_re;

	assign re_ok   = i_wr_re && writes_en;
	assign last_re = re_ok && (wcnt == CW'(LANES - 1)); // Final lane requested

	always_ff @(posedge clk) begin
		if (re_ok) begin
			data <= hold[0];
			for (int l = 0; l < LANES - 1; l++) hold[l] <= hold[l + 1];
		end
		if (i_result_stb) hold <= i_result; // Wins over the shift
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			writes_en <= 1'b0;
			valid     <= 1'b0;
			wcnt      <= '0;
			o_full    <= 1'b0;
			o_wr_done <= 1'b0;
			addr      <= '0;
		end else begin
			valid     <= re_ok;   // Word shows the cycle after re
			o_wr_done <= last_re; // Together with the last valid
			if (re_ok) wcnt <= last_re ? '0 : wcnt + 1'b1;
			if (last_re) begin
				writes_en <= 1'b0;
				o_full    <= 1'b0;
			end
			if (i_result_stb) begin
				writes_en <= 1'b1;
				o_full    <= 1'b1;
				wcnt      <= '0;
			end
			if (i_start) addr <= i_cfg.result_start;
			else if (o_wr_done) addr <= addr + LANES_A; // Next output slot
		end
	end

	assign o_wr = '{writes_en: writes_en, addr: addr, data: data, valid: valid};

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f flist.f --top-module tb_pool_engine -o tb_pool_engine; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_pool_engine 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1

/* tests/tb_dma_mem.sv */
`timescale 1ns/1ps

module tb_dma_mem import eng_bus_pkg::*; #(
	parameter int LANES  = DEF_LANES,
	parameter int MEM_AW = 12
) (
	input  logic              clk,
	input  logic              rst,
	input  int                i_rd_gap,  // Longest idle stretch before a read word
	input  int                i_wr_gap,  // Longest idle stretch before an re strobe
	input  rd_cmd_t           i_rd,
	output logic              o_rd_we,
	output logic [DATA_W-1:0] o_rd_data,
	input  wr_cmd_t           i_wr,
	output logic              o_wr_re
);

	localparam int WORDS = 1 << MEM_AW;

	logic [DATA_W-1:0] mem [0:WORDS-1]; // Feature map image, results land here too
	integer            seed;
	int                rd_wait;         // Cycles left before the next read word
	int                wr_wait;         // Cycles left before the next re
	int                re_cnt;          // re strobes given for the held atom
	int                wr_word;         // Lane of the next written word

	initial begin
		seed      = 32'he92c;
		o_rd_we   = 1'b0;
		o_rd_data = '0;
		o_wr_re   = 1'b0;
		rd_wait   = 0;
		wr_wait   = 0;
		for (int i = 0; i < WORDS; i++) mem[i] = DATA_W'($random(seed));
	end

	// Never two words in a row, so addr has moved before the next look
	always @(posedge clk) begin
		if (rst) begin
			o_rd_we <= 1'b0;
			rd_wait <= 0;
		end else begin
			o_rd_we <= 1'b0;
			if (i_rd.en && !o_rd_we) begin
				if (rd_wait > 0) rd_wait <= rd_wait - 1;
				else begin
					o_rd_we   <= 1'b1;
					o_rd_data <= mem[i_rd.addr[MEM_AW-1:0]];
					rd_wait   <= int'($unsigned($random(seed)) % $unsigned(i_rd_gap + 1));
				end
			end
		end
	end

	// LANES re strobes per held atom, then wait for writes_en to drop
	always @(posedge clk) begin
		if (rst) begin
			o_wr_re <= 1'b0;
			wr_wait <= 0;
			re_cnt  <= 0;
			wr_word <= 0;
		end else begin
			o_wr_re <= 1'b0;
			if (!i_wr.writes_en) re_cnt <= 0; // Atom gone, rearm
			else if (re_cnt < LANES) begin
				if (wr_wait > 0) wr_wait <= wr_wait - 1;
				else begin
					o_wr_re <= 1'b1;
					re_cnt  <= re_cnt + 1;
					wr_wait <= int'($unsigned($random(seed)) % $unsigned(i_wr_gap + 1));
				end
			end
			if (i_wr.valid) begin // Store lane words at the atom address
				mem[i_wr.addr[MEM_AW-1:0] + MEM_AW'(wr_word)] <= i_wr.data;
				wr_word <= (wr_word == LANES - 1) ? 0 : wr_word + 1;
			end
		end
	end

endmodule

/* tests/tb_pool_engine.sv */
`timescale 1ns/1ps

module tb_pool_engine import eng_cfg_pkg::*, eng_bus_pkg::*; ();

	localparam int LANES  = DEF_LANES;
	localparam int N_CMDS = 4; // Pooling commands that run a row

	logic              clk;
	logic              rst;
	logic              eng_valid;
	layer_cfg_t        cfg;
	logic              eng_ready;
	rd_cmd_t           rd;
	logic              rd_we;
	logic [DATA_W-1:0] rd_data;
	wr_cmd_t           wr;
	logic              wr_re;
	int                rd_gap;
	int                wr_gap;

	logic [ADDR_W-1:0] exp_rd[$];    // Read addresses still to come
	logic [ADDR_W-1:0] exp_waddr[$]; // Atom address per lane word
	logic [DATA_W-1:0] exp_wdata[$]; // Pooled lane words in write order

	always #5 clk = ~clk;

	pool_engine #(.LANES(LANES)) pool_engine_inst (
		.clk, .rst, .i_engine_valid(eng_valid), .i_cfg(cfg), .o_engine_ready(eng_ready),
		.o_rd(rd), .i_rd_we(rd_we), .i_rd_data(rd_data), .o_wr(wr), .i_wr_re(wr_re)
	);

	tb_dma_mem #(.LANES(LANES)) dma_mem_inst (
		.clk, .rst, .i_rd_gap(rd_gap), .i_wr_gap(wr_gap), .i_rd(rd), .o_rd_we(rd_we),
		.o_rd_data(rd_data), .i_wr(wr), .o_wr_re(wr_re)
	);

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic layer_cfg_t make_cfg(input op_e op, input int k, input int s,
		input int iside, input int oside, input int dstart, input int rstart);
		return '{op: op, stride: 4'(s), kernel: 8'(k), i_side: 8'(iside), o_side: 8'(oside),
			data_start: ADDR_W'(dstart), result_start: ADDR_W'(rstart)};
	endfunction

	// Word j of atom a in window o, atoms row-major inside the window
	function automatic int word_addr(input layer_cfg_t c, input int o, input int a, input int j);
		int k;
		k = int'(c.kernel);
		return int'(c.data_start) + o * int'(c.stride) * LANES
			+ (a / k) * int'(c.i_side) * LANES + (a % k) * LANES + j;
	endfunction

	// Unsigned max, or window sum divided by kernel squared
	function automatic logic [DATA_W-1:0] pooled_lane(input layer_cfg_t c, input int o, input int l);
		int acc;
		int v;
		int n;
		acc = 0;
		n   = int'(c.kernel) * int'(c.kernel);
		for (int a = 0; a < n; a++) begin
			v = int'(dma_mem_inst.mem[word_addr(c, o, a, l)]);
			if (c.op == OP_MAXPOOL) acc = (v > acc) ? v : acc;
			else acc = acc + v;
		end
		if (c.op == OP_AVEPOOL) acc = acc / n;
		return DATA_W'(acc);
	endfunction

	// No traffic, ready held at the given level
	task automatic check_quiet(input logic ready);
		repeat (12) begin
			@(posedge clk);
			check_value("o_engine_ready", 32'(eng_ready), 32'(ready));
			check_value("o_rd.en", 32'(rd.en), 32'd0);
			check_value("o_wr.writes_en", 32'(wr.writes_en), 32'd0);
			check_value("o_wr.valid", 32'(wr.valid), 32'd0);
		end
	endtask

	task automatic send_command(input layer_cfg_t c);
		@(posedge clk);
		cfg       <= c;
		eng_valid <= 1'b1; // One cycle pulse
		@(posedge clk);
		eng_valid <= 1'b0;
	endtask

	// Queue the expected traffic, run one row, then wait for ready
	task automatic run_pool(input layer_cfg_t c, input int rgap, input int wgap);
		int k;
		k = int'(c.kernel);
		rd_gap <= rgap;
		wr_gap <= wgap;
		for (int o = 0; o < int'(c.o_side); o++) begin
			for (int a = 0; a < k * k; a++) begin
				for (int j = 0; j < LANES; j++) exp_rd.push_back(ADDR_W'(word_addr(c, o, a, j)));
			end
			for (int l = 0; l < LANES; l++) begin
				exp_wdata.push_back(pooled_lane(c, o, l));
				exp_waddr.push_back(ADDR_W'(int'(c.result_start) + o * LANES));
			end
		end
		send_command(c);
		@(posedge clk);
		while (!eng_ready) @(posedge clk);
		check_value("read words left at ready", 32'(exp_rd.size()), 32'd0);
		check_value("write words left at ready", 32'(exp_wdata.size()), 32'd0);
		check_quiet(1'b1); // Ready stays up until the next command
	endtask

	always @(posedge clk) begin
		if (!rst && rd_we) begin
			assert (exp_rd.size() != 0) else begin
				$display("A read word was taken while no read was expected");
				abort_run();
			end
			if (exp_rd.size() != 0) begin
				check_value("o_rd.addr", 32'(rd.addr), 32'(exp_rd[0]));
				exp_rd.delete(0);
			end
		end
	end

	always @(posedge clk) begin
		if (!rst && wr.valid) begin
			assert (exp_wdata.size() != 0) else begin
				$display("A result word was written while no result was expected");
				abort_run();
			end
			if (exp_wdata.size() != 0) begin
				check_value("o_wr.data", 32'(wr.data), 32'(exp_wdata[0]));
				check_value("o_wr.addr", 32'(wr.addr), 32'(exp_waddr[0]));
				exp_wdata.delete(0);
				exp_waddr.delete(0);
			end
		end
	end

	initial begin
		clk       = 1'b0;
		rst       = 1'b1;
		eng_valid = 1'b0;
		cfg       = '0;
		rd_gap    = 0;
		wr_gap    = 0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		check_quiet(1'b0);
		send_command(make_cfg(op_e'(3'd3), 2, 2, 16, 4, 'h040, 'h800)); // Not a pooling op
		check_quiet(1'b0);
		run_pool(make_cfg(OP_MAXPOOL, 2, 2, 16, 7, 'h040, 'h800), 2, 2);
		send_command(make_cfg(op_e'(3'd1), 2, 2, 16, 4, 'h040, 'h800));
		check_quiet(1'b1);
		run_pool(make_cfg(OP_AVEPOOL, 4, 1, 10, 6, 'h100, 'h900), 0, 1); // Overlapping windows
		run_pool(make_cfg(OP_MAXPOOL, 2, 1, 10, 9, 'h200, 'hA00), 1, 40); // Slow write side
		run_pool(make_cfg(OP_AVEPOOL, 2, 2, 14, 6, 'h280, 'hB00), 3, 12);
		$display("=== PASS ===");
		$finish;
	end

	// Cycle budget per command covers the slowest DMA gaps
	initial begin
		repeat (4000 * N_CMDS) @(posedge clk);
		$display("Timeout: the engine did not complete the command sequence");
		abort_run();
	end

endmodule
